// ==== hdl/core_pkg.sv ====
/*
 * Core package: OBI request/response structs, instruction word views,
 * opcodes, FSM states and the control/status bundles of the small core
 */
`default_nettype none

package core_pkg;

    typedef struct packed {
        logic        req;
        logic        we;
        logic [3:0]  be;
        logic [31:0] addr;
        logic [31:0] wdata;
    } obi_req_t;

    typedef struct packed {
        logic        gnt;
        logic        rvalid;
        logic [31:0] rdata;
    } obi_resp_t;

    // Major opcodes of the supported RV32I subset
    typedef enum logic [6:0] {
        OP     = 7'b0110011,
        OP_IMM = 7'b0010011,
        LOAD   = 7'b0000011,
        STORE  = 7'b0100011,
        BRANCH = 7'b1100011,
        SYSTEM = 7'b1110011
    } opcode_e;

    localparam logic [2:0]  FUNCT3_BEQ  = 3'b000;
    localparam logic [2:0]  FUNCT3_BNE  = 3'b001;
    localparam logic [11:0] FUNCT12_WFI = 12'h105;

    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        opcode_e    opcode;
    } instr_r_t;

    typedef struct packed {
        logic [11:0] imm;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        opcode_e     opcode;
    } instr_i_t;

    typedef struct packed {
        logic [6:0] imm_hi;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] imm_lo;
        opcode_e    opcode;
    } instr_s_t;

    // Same layout as S, bits scrambled into imm[12|10:5] and imm[4:1|11]
    typedef struct packed {
        logic [6:0] off_hi;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] off_lo;
        opcode_e    opcode;
    } instr_b_t;

    typedef union packed {
        instr_r_t r;
        instr_i_t i;
        instr_s_t s;
        instr_b_t b;
    } instr_u;

    typedef enum logic [2:0] {
        FETCH,
        FETCH_WAIT,
        EXECUTE,
        MEM,
        MEM_WAIT,
        SLEEP
    } ctrl_state_e;

    typedef struct packed {
        logic pc_adv;
        logic pc_load;
        logic rf_we;
        logic wb_from_mem;
    } exec_ctrl_t;

    typedef struct packed {
        logic is_mem;
        logic is_store;
        logic is_sleep;
        logic take_branch;
    } exec_info_t;

endpackage

`default_nettype wire

// ==== hdl/core_ctrl_fsm.sv ====
/*
 * Core control FSM: sequences fetch, execute, data access and sleep,
 * drives the OBI req bits and holds the fetched instruction
 */
`timescale 1ns/100ps
`default_nettype none

module core_ctrl_fsm (
    input  logic                 clk_i,
    input  logic                 arst_n_i,
    input  core_pkg::exec_info_t info_i,
    input  core_pkg::obi_resp_t  instr_resp_i,
    input  core_pkg::obi_resp_t  data_resp_i,
    output logic                 instr_req_o,
    output logic                 data_req_o,
    output core_pkg::instr_u     instr_o,
    output core_pkg::exec_ctrl_t ctrl_o,
    output logic                 sleep_o
);
    import core_pkg::*;

    ctrl_state_e state_q, state_d;
    logic        instr_req_q, instr_req_d;
    logic        data_req_q, data_req_d;
    instr_u      instr_q;
    logic        writes_rd;

    // Only ALU instructions write back from EXECUTE
    assign writes_rd = (instr_q.r.opcode == OP) || (instr_q.r.opcode == OP_IMM);

    always_comb begin
        state_d     = state_q;
        instr_req_d = instr_req_q;
        data_req_d  = data_req_q;
        ctrl_o      = '0;
        case (state_q)
            FETCH: begin
                if (!instr_req_q) begin
                    // First fetch after reset
                    instr_req_d = 1'b1;
                end else if (instr_resp_i.gnt) begin
                    instr_req_d = 1'b0;
                    state_d     = FETCH_WAIT;
                end
            end
            FETCH_WAIT: begin
                if (instr_resp_i.rvalid) begin
                    state_d = EXECUTE;
                end
            end
            EXECUTE: begin
                if (info_i.is_sleep) begin
                    state_d = SLEEP;
                end else if (info_i.is_mem) begin
                    data_req_d = 1'b1;
                    state_d    = MEM;
                end else begin
                    ctrl_o.pc_load = info_i.take_branch;
                    ctrl_o.pc_adv  = !info_i.take_branch;
                    ctrl_o.rf_we   = writes_rd;
                    instr_req_d    = 1'b1;
                    state_d        = FETCH;
                end
            end
            MEM: begin
                if (data_resp_i.gnt) begin
                    data_req_d = 1'b0;
                    state_d    = MEM_WAIT;
                end
            end
            MEM_WAIT: begin
                ctrl_o.wb_from_mem = 1'b1;
                if (data_resp_i.rvalid) begin
                    ctrl_o.pc_adv = 1'b1;
                    ctrl_o.rf_we  = !info_i.is_store;
                    instr_req_d   = 1'b1;
                    state_d       = FETCH;
                end
            end
            SLEEP: begin
                state_d = SLEEP;
            end
            default: begin
                state_d = FETCH;
            end
        endcase
    end

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state_q     <= FETCH;
            instr_req_q <= 1'b0;
            data_req_q  <= 1'b0;
        end else begin
            state_q     <= state_d;
            instr_req_q <= instr_req_d;
            data_req_q  <= data_req_d;
        end
    end

    always_ff @(posedge clk_i) begin
        if ((state_q == FETCH_WAIT) && instr_resp_i.rvalid) begin
            instr_q <= instr_resp_i.rdata;
        end
    end

    assign instr_req_o = instr_req_q;
    assign data_req_o  = data_req_q;
    assign instr_o     = instr_q;
    assign sleep_o     = (state_q == SLEEP);

endmodule

`default_nettype wire

// ==== hdl/core_pc.sv ====
/*
 * Program counter: starts at the boot address, steps by four
 * or takes a branch target
 */
`timescale 1ns/100ps
`default_nettype none

module core_pc #(
    parameter logic [31:0] BOOT_ADDR = 32'h0000_0180
) (
    input  logic                 clk_i,
    input  logic                 arst_n_i,
    input  core_pkg::exec_ctrl_t ctrl_i,
    input  logic [31:0]          target_i,
    output logic [31:0]          pc_o
);

    logic [31:0] pc_q;

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            pc_q <= BOOT_ADDR;
        end else if (ctrl_i.pc_load) begin
            pc_q <= target_i;
        end else if (ctrl_i.pc_adv) begin
            pc_q <= pc_q + 32'd4;
        end
    end

    assign pc_o = pc_q;

endmodule

`default_nettype wire

// ==== hdl/core_regfile.sv ====
/*
 * Register file: two read ports, one write port, x0 tied to zero
 */
`timescale 1ns/100ps
`default_nettype none

module core_regfile #(
    parameter int unsigned NUM_REGS = 16,
    localparam int unsigned AW      = $clog2(NUM_REGS)
) (
    input  logic                 clk_i,
    input  logic                 arst_n_i,
    input  logic [AW-1:0]        raddr_a_i,
    input  logic [AW-1:0]        raddr_b_i,
    output logic [31:0]          rdata_a_o,
    output logic [31:0]          rdata_b_o,
    input  logic [AW-1:0]        waddr_i,
    input  logic [31:0]          wdata_i,
    input  core_pkg::exec_ctrl_t ctrl_i
);

    logic [NUM_REGS-1:0][31:0] regs_q;

    // Writes to x0 are dropped, so it keeps its reset value
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            regs_q <= '0;
        end else if (ctrl_i.rf_we && (waddr_i != '0)) begin
            regs_q[waddr_i] <= wdata_i;
        end
    end

    assign rdata_a_o = regs_q[raddr_a_i];
    assign rdata_b_o = regs_q[raddr_b_i];

endmodule

`default_nettype wire

// ==== hdl/core_exec.sv ====
/*
 * Decode and execute: immediates, add/sub, branch compare,
 * load/store address and write-back select
 */
`timescale 1ns/100ps
`default_nettype none

module core_exec (
    input  core_pkg::instr_u     instr_i,
    input  logic [31:0]          pc_i,
    input  logic [31:0]          rs1_i,
    input  logic [31:0]          rs2_i,
    input  logic [31:0]          mem_rdata_i,
    input  core_pkg::exec_ctrl_t ctrl_i,
    output core_pkg::exec_info_t info_o,
    output logic [31:0]          target_o,
    output logic [31:0]          wb_data_o,
    output logic [31:0]          data_addr_o,
    output logic [31:0]          data_wdata_o
);
    import core_pkg::*;

    opcode_e     opcode;
    logic [31:0] imm_i;
    logic [31:0] imm_s;
    logic [31:0] off_b;
    logic [31:0] alu_res;
    logic        rs_equal;
    logic        branch_cond;

    assign opcode = instr_i.r.opcode;

    // Sign-extended immediates
    assign imm_i = {{20{instr_i.i.imm[11]}}, instr_i.i.imm};
    assign imm_s = {{20{instr_i.s.imm_hi[6]}}, instr_i.s.imm_hi, instr_i.s.imm_lo};

    // B offset: imm[12], imm[11], imm[10:5], imm[4:1], implicit zero
    assign off_b = {{19{instr_i.b.off_hi[6]}}, instr_i.b.off_hi[6], instr_i.b.off_lo[0],
                    instr_i.b.off_hi[5:0], instr_i.b.off_lo[4:1], 1'b0};

    always_comb begin
        if (opcode == OP) begin
            // funct7 bit 5 selects SUB
            alu_res = instr_i.r.funct7[5] ? (rs1_i - rs2_i) : (rs1_i + rs2_i);
        end else begin
            alu_res = rs1_i + imm_i;
        end
    end

    assign rs_equal = (rs1_i == rs2_i);

    always_comb begin
        case (instr_i.b.funct3)
            FUNCT3_BEQ: branch_cond = rs_equal;
            FUNCT3_BNE: branch_cond = !rs_equal;
            default:    branch_cond = 1'b0;
        endcase
    end

    assign info_o.is_mem      = (opcode == LOAD) || (opcode == STORE);
    assign info_o.is_store    = (opcode == STORE);
    assign info_o.is_sleep    = (opcode == SYSTEM) && (instr_i.i.imm == FUNCT12_WFI);
    assign info_o.take_branch = (opcode == BRANCH) && branch_cond;

    assign target_o     = pc_i + off_b;
    assign data_addr_o  = rs1_i + ((opcode == STORE) ? imm_s : imm_i);
    assign data_wdata_o = rs2_i;

    // Loads take the response word, everything else the ALU
    assign wb_data_o = ctrl_i.wb_from_mem ? mem_rdata_i : alu_res;

endmodule

`default_nettype wire

// ==== hdl/cpu_subsystem.sv ====
/*
 * CPU subsystem: small multi-cycle RV32I core with OBI instruction
 * and data ports, halts fetching on WFI
 */
`timescale 1ns/100ps
`default_nettype none

module cpu_subsystem #(
    parameter logic [31:0] BOOT_ADDR = 32'h0000_0180,
    parameter int unsigned NUM_REGS  = 16
) (
    input  logic                clk_i,
    input  logic                arst_n_i,

    // Instruction port
    output core_pkg::obi_req_t  core_instr_req_o,
    input  core_pkg::obi_resp_t core_instr_resp_i,

    // Data port
    output core_pkg::obi_req_t  core_data_req_o,
    input  core_pkg::obi_resp_t core_data_resp_i,

    output logic                core_sleep_o
);
    import core_pkg::*;

    localparam int unsigned RF_AW = $clog2(NUM_REGS);

    exec_ctrl_t  ctrl;
    exec_info_t  info;
    instr_u      instr;
    logic        instr_req;
    logic        data_req;
    logic [31:0] pc;
    logic [31:0] target;
    logic [31:0] wb_data;
    logic [31:0] rs1_data;
    logic [31:0] rs2_data;
    logic [31:0] data_addr;
    logic [31:0] data_wdata;

    core_ctrl_fsm u_ctrl_fsm (
        .clk_i       (clk_i),
        .arst_n_i    (arst_n_i),
        .info_i      (info),
        .instr_resp_i(core_instr_resp_i),
        .data_resp_i (core_data_resp_i),
        .instr_req_o (instr_req),
        .data_req_o  (data_req),
        .instr_o     (instr),
        .ctrl_o      (ctrl),
        .sleep_o     (core_sleep_o)
    );

    core_pc #(
        .BOOT_ADDR(BOOT_ADDR)
    ) u_pc (
        .clk_i   (clk_i),
        .arst_n_i(arst_n_i),
        .ctrl_i  (ctrl),
        .target_i(target),
        .pc_o    (pc)
    );

    core_regfile #(
        .NUM_REGS(NUM_REGS)
    ) u_regfile (
        .clk_i    (clk_i),
        .arst_n_i (arst_n_i),
        .raddr_a_i(instr.r.rs1[RF_AW-1:0]),
        .raddr_b_i(instr.r.rs2[RF_AW-1:0]),
        .rdata_a_o(rs1_data),
        .rdata_b_o(rs2_data),
        .waddr_i  (instr.r.rd[RF_AW-1:0]),
        .wdata_i  (wb_data),
        .ctrl_i   (ctrl)
    );

    core_exec u_exec (
        .instr_i     (instr),
        .pc_i        (pc),
        .rs1_i       (rs1_data),
        .rs2_i       (rs2_data),
        .mem_rdata_i (core_data_resp_i.rdata),
        .ctrl_i      (ctrl),
        .info_o      (info),
        .target_o    (target),
        .wb_data_o   (wb_data),
        .data_addr_o (data_addr),
        .data_wdata_o(data_wdata)
    );

    // Instruction fetches are full-word reads from the PC
    assign core_instr_req_o = '{req: instr_req, we: 1'b0, be: 4'hF, addr: pc, wdata: '0};

    // Only word accesses are supported on the data port
    assign core_data_req_o = '{
        req:   data_req,
        we:    info.is_store,
        be:    4'hF,
        addr:  data_addr,
        wdata: data_wdata
    };

endmodule

`default_nettype wire

// ==== tests/cpu_subsystem_assert.sv ====
/*
 * OBI protocol and control checks bound into the CPU subsystem
 */
`timescale 1ns/100ps
`default_nettype none

module cpu_subsystem_assert (
    input logic                clk_i,
    input logic                arst_n_i,
    input core_pkg::obi_req_t  instr_req_i,
    input core_pkg::obi_resp_t instr_resp_i,
    input core_pkg::obi_req_t  data_req_i,
    input core_pkg::obi_resp_t data_resp_i,
    input logic                sleep_i
);

    // Request and all its fields hold until granted
    instr_req_stable: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        instr_req_i.req && !instr_resp_i.gnt |=> $stable(instr_req_i))
        else $error("Instruction request changed before grant");

    data_req_stable: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        data_req_i.req && !data_resp_i.gnt |=> $stable(data_req_i))
        else $error("Data request changed before grant");

    // Fetches are aligned word reads
    instr_word_read: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        instr_req_i.req |-> !instr_req_i.we && (instr_req_i.addr[1:0] == 2'b00))
        else $error("Write or unaligned address on the instruction port");

    no_req_asleep: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        sleep_i |-> !(instr_req_i.req || data_req_i.req))
        else $error("Request while the core sleeps");

    one_port_busy: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        !(instr_req_i.req && data_req_i.req))
        else $error("Both ports request at once");

endmodule

bind cpu_subsystem cpu_subsystem_assert u_assert (
    .clk_i       (clk_i),
    .arst_n_i    (arst_n_i),
    .instr_req_i (core_instr_req_o),
    .instr_resp_i(core_instr_resp_i),
    .data_req_i  (core_data_req_o),
    .data_resp_i (core_data_resp_i),
    .sleep_i     (core_sleep_o)
);

`default_nettype wire

// ==== tests/tb_cpu_subsystem.sv ====
/*
 * Testbench for the CPU subsystem with OBI instruction and data memory models
 * loaded from a data file and store checking against expected sequences
 */
`timescale 1ns/100ps
`default_nettype none

module tb_cpu_subsystem;
    import core_pkg::*;

    localparam logic [31:0] BOOT_ADDR = 32'h0000_0180;
    localparam logic [31:0] WFI_WORD  = 32'h1050_0073;
    localparam int          MEM_WORDS = 1024;

    logic      clk_i;
    logic      arst_n_i;
    obi_req_t  instr_req;
    obi_resp_t instr_resp;
    obi_req_t  data_req;
    obi_resp_t data_resp;
    logic      core_sleep;

    logic [31:0] imem [0:MEM_WORDS-1];
    logic [31:0] dmem [0:MEM_WORDS-1];
    logic        imem_valid [0:MEM_WORDS-1];

    // Data file contents with one entry per P, D or S line
    string       test_name [$];
    int          test_count [$];
    byte         ent_kind [$];
    int          ent_test [$];
    logic [31:0] ent_addr [$];
    logic [31:0] ent_data [$];

    // State of the running test
    string       cur_name;
    logic [31:0] exp_addr [$];
    logic [31:0] exp_data [$];
    int          store_idx;
    int          test_errors;
    logic        first_fetch;

    int tests_passed;
    int tests_failed;
    int total_errors;
    int parse_errors;
    int watchdog_cycles;

    cpu_subsystem #(
        .BOOT_ADDR(BOOT_ADDR),
        .NUM_REGS (16)
    ) dut0 (
        .clk_i            (clk_i),
        .arst_n_i         (arst_n_i),
        .core_instr_req_o (instr_req),
        .core_instr_resp_i(instr_resp),
        .core_data_req_o  (data_req),
        .core_data_resp_i (data_resp),
        .core_sleep_o     (core_sleep)
    );

    always #4 clk_i = ~clk_i;

    task automatic compare_value(input string what, input logic [31:0] expected,
                                 input logic [31:0] actual);
        if (actual !== expected) begin
            $display("Error: test %s, %s, expected %h, actual %h",
                     cur_name, what, expected, actual);
            test_errors++;
        end
    endtask

    // Inputs change 1 ns after the rising edge
    task automatic step_cycles(input int n);
        repeat (n) begin
            @(posedge clk_i);
            #1;
        end
    endtask

    function automatic logic in_memory(input logic [31:0] addr);
        return addr[31:12] == '0;
    endfunction

    task automatic serve_fetch();
        logic [31:0] addr;
        int unsigned delay;
        step_cycles($urandom_range(3));
        addr = instr_req.addr;
        compare_value("fetch byte enables", 32'hF, instr_req.be);
        if (first_fetch) begin
            compare_value("first fetch address", BOOT_ADDR, addr);
            first_fetch = 1'b0;
        end
        instr_resp.gnt = 1'b1;
        step_cycles(1);
        instr_resp.gnt = 1'b0;
        delay = $urandom_range(3);
        step_cycles(delay);
        if (in_memory(addr) && imem_valid[addr[11:2]]) begin
            instr_resp.rdata = imem[addr[11:2]];
        end else begin
            $display("Test %s: fetch from %h outside the loaded program", cur_name, addr);
            test_errors++;
            instr_resp.rdata = WFI_WORD;
        end
        instr_resp.rvalid = 1'b1;
        step_cycles(1);
        instr_resp.rvalid = 1'b0;
    endtask

    task automatic serve_data();
        logic [31:0] addr;
        logic [31:0] wdata;
        logic        we;
        step_cycles($urandom_range(3));
        addr  = data_req.addr;
        wdata = data_req.wdata;
        we    = data_req.we;
        compare_value("data byte enables", 32'hF, data_req.be);
        data_resp.gnt = 1'b1;
        step_cycles(1);
        data_resp.gnt = 1'b0;
        step_cycles($urandom_range(3));
        data_resp.rdata = '0;
        if (!in_memory(addr)) begin
            $display("Test %s: data access to %h outside the memory model", cur_name, addr);
            test_errors++;
        end else if (we) begin
            if (store_idx < exp_addr.size()) begin
                compare_value("store address", exp_addr[store_idx], addr);
                compare_value("store data", exp_data[store_idx], wdata);
            end else begin
                $display("Test %s: store of %h to %h was not expected", cur_name, wdata, addr);
                test_errors++;
            end
            store_idx++;
            dmem[addr[11:2]] = wdata;
        end else begin
            data_resp.rdata = dmem[addr[11:2]];
        end
        data_resp.rvalid = 1'b1;
        step_cycles(1);
        data_resp.rvalid = 1'b0;
    endtask

    // Only one port is busy at a time, so one process answers both
    initial begin : obi_memory
        int seed;
        seed        = $urandom(17424);
        instr_resp  = '0;
        data_resp   = '0;
        first_fetch = 1'b0;
        forever begin
            step_cycles(1);
            if (arst_n_i && instr_req.req) begin
                serve_fetch();
            end else if (arst_n_i && data_req.req) begin
                serve_data();
            end
        end
    end

    task automatic read_data_file(output logic ok);
        int          fd;
        int          count;
        int          status;
        string       tag;
        string       name;
        logic [31:0] addr;
        logic [31:0] word;
        logic [8*256-1:0] rest;
        ok = 1'b0;
        fd = $fopen("tests/program_input.txt", "r");
        if (fd != 0) begin
            ok = 1'b1;
            while ($fscanf(fd, "%s", tag) == 1) begin
                if (tag == "#") begin
                    status = $fgets(rest, fd);
                end else if (tag == "T") begin
                    status = $fscanf(fd, "%s %d", name, count);
                    test_name.push_back(name);
                    test_count.push_back(count);
                end else if ((tag == "P" || tag == "D" || tag == "S") && test_name.size() > 0) begin
                    status = $fscanf(fd, "%h %h", addr, word);
                    ent_kind.push_back(tag[0]);
                    ent_test.push_back(test_name.size() - 1);
                    ent_addr.push_back(addr);
                    ent_data.push_back(word);
                end else begin
                    $display("Data file entry %s is not understood", tag);
                    parse_errors++;
                end
            end
            $fclose(fd);
        end
    endtask

    task automatic load_memories(input int t);
        int          i;
        logic [31:0] addr;
        exp_addr.delete();
        exp_data.delete();
        for (i = 0; i < MEM_WORDS; i++) begin
            imem[i]       = '0;
            imem_valid[i] = 1'b0;
            dmem[i]       = 32'h5A5A_0000 ^ (i * 4);
        end
        for (i = 0; i < ent_kind.size(); i++) begin
            addr = ent_addr[i];
            if (ent_test[i] == t) begin
                case (ent_kind[i])
                    "P": begin
                        imem[addr[11:2]]       = ent_data[i];
                        imem_valid[addr[11:2]] = 1'b1;
                    end
                    "D": dmem[addr[11:2]] = ent_data[i];
                    default: begin
                        exp_addr.push_back(addr);
                        exp_data.push_back(ent_data[i]);
                    end
                endcase
            end
        end
    endtask

    task automatic run_test(input int t);
        int i;
        cur_name    = test_name[t];
        test_errors = 0;
        store_idx   = 0;
        arst_n_i    = 1'b0;
        load_memories(t);
        step_cycles(3);
        compare_value("reqs and sleep in reset", 32'd0,
                      {instr_req.req, data_req.req, core_sleep});
        first_fetch = 1'b1;
        arst_n_i    = 1'b1;
        step_cycles(1);
        while (!core_sleep) begin
            step_cycles(1);
        end
        // Bus stays quiet once asleep
        for (i = 0; i < 10; i++) begin
            step_cycles(1);
            if (instr_req.req || data_req.req) begin
                $display("Test %s: request on the bus after WFI", cur_name);
                test_errors++;
            end
        end
        if (store_idx < exp_addr.size()) begin
            $display("Test %s: core went to sleep after %0d of %0d stores",
                     cur_name, store_idx, exp_addr.size());
            test_errors++;
        end
        if (test_errors == 0) begin
            $display("Test %s: passed", cur_name);
            tests_passed++;
        end else begin
            $display("Test %s: failed with %0d errors", cur_name, test_errors);
            tests_failed++;
        end
        total_errors += test_errors;
    endtask

    initial begin : watchdog
        wait (watchdog_cycles > 0);
        repeat (watchdog_cycles) @(posedge clk_i);
        $display("Run did not complete within %0d cycles", watchdog_cycles);
        $display("Finished with errors");
        $finish;
    end

    initial begin : run_all
        logic ok;
        int   t;
        int   total_instr;
        clk_i        = 1'b0;
        arst_n_i     = 1'b0;
        tests_passed = 0;
        tests_failed = 0;
        total_errors = 0;
        parse_errors = 0;
        test_errors  = 0;
        store_idx    = 0;
        read_data_file(ok);
        if (!ok) begin
            $display("Could not open the data file tests/program_input.txt");
            $display("Finished with errors");
            $finish;
        end else begin
            if (test_name.size() == 0) begin
                $display("Data file holds no tests");
                parse_errors++;
            end
            total_instr = 0;
            for (t = 0; t < test_name.size(); t++) begin
                total_instr += test_count[t];
            end
            // Worst case per instruction is about 18 cycles with full delays
            watchdog_cycles = total_instr * 20 + test_name.size() * 40 + 100;
            for (t = 0; t < test_name.size(); t++) begin
                run_test(t);
            end
            $display("%0d tests: %0d passed, %0d failed, %0d errors",
                     test_name.size(), tests_passed, tests_failed, total_errors + parse_errors);
            if (tests_failed == 0 && parse_errors == 0) begin
                $display("Finished with no errors");
            end else begin
                $display("Finished with errors");
            end
            $finish;
        end
    end

endmodule

`default_nettype wire

// ==== tests/program_input.txt ====
# T name executed-instruction-count | P addr instr | D addr initial-data | S addr store-data
# Addresses and words in hex, one test per T line followed by its entries
T alu_ops 12
P 00000180 00500093
P 00000184 FFD00113
P 00000188 002081B3
P 0000018C 40208233
P 00000190 00708013
P 00000194 10302023
P 00000198 10402223
P 0000019C 10002423
P 000001A0 10202623
P 000001A4 12000293
P 000001A8 FE12AC23
P 000001AC 10500073
S 00000100 00000002
S 00000104 00000008
S 00000108 00000000
S 0000010C FFFFFFFD
S 00000118 00000005
T load_store 8
P 00000180 20002083
P 00000184 20402103
P 00000188 002081B3
P 0000018C 20102423
P 00000190 20302623
P 00000194 40118233
P 00000198 20402823
P 0000019C 10500073
D 00000200 12345678
D 00000204 00000010
S 00000208 12345678
S 0000020C 12345688
S 00000210 00000010
T branch_loop 18
P 00000180 00300093
P 00000184 30000113
P 00000188 00112023
P 0000018C 00410113
P 00000190 FFF08093
P 00000194 FE009AE3
P 00000198 00008463
P 0000019C 00202023
P 000001A0 00010463
P 000001A4 32202023
P 000001A8 10500073
S 00000300 00000003
S 00000304 00000002
S 00000308 00000001
S 00000320 0000030C

// ==== verilog.f ====
hdl/core_pkg.sv
hdl/core_ctrl_fsm.sv
hdl/core_pc.sv
hdl/core_regfile.sv
hdl/core_exec.sv
hdl/cpu_subsystem.sv
tests/cpu_subsystem_assert.sv
tests/tb_cpu_subsystem.sv

// ==== Bender.yml ====
package:
  name: cpu_subsystem

sources:
  - hdl/core_pkg.sv
  - hdl/core_ctrl_fsm.sv
  - hdl/core_pc.sv
  - hdl/core_regfile.sv
  - hdl/core_exec.sv
  - hdl/cpu_subsystem.sv
  - target: test
    files:
      - tests/cpu_subsystem_assert.sv
      - tests/tb_cpu_subsystem.sv
